// File: src.f
+incdir+src
src/uart_pkg.sv
src/monitor_pkg.sv
src/uart_receiver.sv
src/command_decoder.sv
src/reply_buffer.sv
src/uart_transmitter.sv
src/debug_uart.sv
tests/debug_uart_tb.sv

// File: Makefile
VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing --timescale 1ns/1ns -j 0
TOP_MODULE ?= debug_uart_tb
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
PASS_MESSAGE ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP_MODULE) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR)

run: compile
	@output="$$(./$(BUILD_DIR)/V$(TOP_MODULE))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/debug_uart_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "debug_uart_cfg.svh"

module debug_uart_tb;

	localparam int clock_period = 20;
	localparam int rounds = 3;
	localparam int command_count = 5 + 4 * rounds;
	localparam int model_depth = 1 << `ADDRESS_WIDTH;

	logic uart_clock = 1'b0;
	logic reset;
	logic uart_rx;
	logic uart_tx;
	logic cpu_continue;
	logic cpu_stop;
	logic cpu_reset;
	logic cpu_step;
	logic [`STEP_WIDTH-1:0] step_count;
	logic [`ADDRESS_WIDTH-1:0] reg_read_address;
	logic [`REG_WIDTH-1:0] reg_read_data;
	logic [`ADDRESS_WIDTH-1:0] reg_write_address;
	logic [`REG_WIDTH-1:0] reg_write_data;
	logic reg_write_enable;
	logic [`ADDRESS_WIDTH-1:0] data_read_address;
	logic [`DATA_WIDTH-1:0] data_read_data;
	logic [`ADDRESS_WIDTH-1:0] data_write_address;
	logic [`DATA_WIDTH-1:0] data_write_data;
	logic data_write_enable;
	logic [`PC_WIDTH-1:0] program_counter;

	logic [`REG_WIDTH-1:0] reg_model [model_depth];
	logic [`DATA_WIDTH-1:0] data_model [model_depth];
	logic [`BYTE_WIDTH-1:0] expected [$];
	logic [`BYTE_WIDTH-1:0] received [$];
	logic [5:0] pulses;
	logic [31:0] rng_state;
	int pulse_count [6] = '{default: 0};
	int pulse_expected [6] = '{default: 0};
	string pulse_names [6] = '{"cpu_continue", "cpu_stop", "cpu_reset", "cpu_step",
		"reg_write_enable", "data_write_enable"};

	debug_uart i_dut (.*);

	always #(clock_period / 2) uart_clock = ~uart_clock;

	assign reg_read_data = reg_model[reg_read_address];
	assign data_read_data = data_model[data_read_address];
	assign pulses = {data_write_enable, reg_write_enable, cpu_step, cpu_reset, cpu_stop,
		cpu_continue};

	function automatic logic [31:0] xorshift(input logic [31:0] value);
		logic [31:0] x;
		x = value ^ (value << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Register file and data memory of the processor
	always @(posedge uart_clock or posedge reset) begin : memory_models
		logic [31:0] fill;
		if (reset) begin
			for (int i = 0; i < model_depth; i++) begin
				fill = xorshift(32'hd72e ^ 32'(i));
				reg_model[i] <= fill[15:0];
				data_model[i] <= fill[23:16];
			end
		end else begin
			if (reg_write_enable)
				reg_model[reg_write_address] <= reg_write_data;
			if (data_write_enable)
				data_model[data_write_address] <= data_write_data;
		end
	end

	always @(posedge uart_clock) begin
		for (int i = 0; i < 6; i++)
			if (pulses[i] === 1'b1)
				pulse_count[i] <= pulse_count[i] + 1;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] wanted);
		if (actual !== wanted)
			fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, actual, wanted));
	endtask

	task automatic check_pulses();
		for (int i = 0; i < 6; i++)
			check_value({pulse_names[i], " pulse count"}, pulse_count[i], pulse_expected[i]);
	endtask

	// Reply text from the typed line and the current model contents
	function automatic string expected_reply(input string line);
		logic [`ADDRESS_WIDTH-1:0] address;
		logic [`REG_WIDTH-1:0] value;
		address = '0;
		value = '0;
		for (int i = 0; i < `ADDRESS_WIDTH && `ADDRESS_FIRST + i < line.len(); i++)
			address = {address[`ADDRESS_WIDTH-2:0], line[`ADDRESS_FIRST + i] == "1"};
		for (int i = 0; i < `REG_WIDTH && `DATA_FIRST + i < line.len(); i++)
			value = {value[`REG_WIDTH-2:0], line[`DATA_FIRST + i] == "1"};
		case (line[0])
			"W": return $sformatf(" %06b %016b", address, value);
			"E": return $sformatf(" %06b %08b", address, value[`DATA_WIDTH-1:0]);
			"G": return $sformatf(" %016b", reg_model[address]);
			"D": return $sformatf(" %08b", data_model[address]);
			"p": return $sformatf(" %07b", program_counter);
			default: return " "; // Pulse commands
		endcase
	endfunction

	task automatic send_char(input logic [`BYTE_WIDTH-1:0] character);
		logic [`BYTE_WIDTH-1:0] data;
		data = character;
		@(posedge uart_clock);
		#2 uart_rx = 1'b0; // Start bit
		repeat (`BYTE_WIDTH) begin
			@(posedge uart_clock);
			#2 uart_rx = data[0];
			data = data >> 1;
		end
		@(posedge uart_clock);
		#2 uart_rx = 1'b1;
		@(posedge uart_clock); // Idle cycle
	endtask

	task automatic run_command(input string line);
		string reply;
		for (int i = 0; i < line.len(); i++)
			expected.push_back(line[i]); // Echo first
		reply = expected_reply(line);
		for (int i = 0; i < reply.len(); i++)
			expected.push_back(reply[i]);
		case (line[0])
			"C": pulse_expected[0]++;
			"S": pulse_expected[1]++;
			"R": pulse_expected[2]++;
			"+": pulse_expected[3]++;
			"W": pulse_expected[4]++;
			"E": pulse_expected[5]++;
			default: ;
		endcase
		for (int i = 0; i < line.len(); i++)
			send_char(line[i]);
		send_char(`ASCII_CR);
		while (expected.size() != 0)
			@(posedge uart_clock);
		repeat (5) @(posedge uart_clock);
		check_pulses();
	endtask

	initial begin : receive_monitor
		logic [`BYTE_WIDTH-1:0] data;
		@(negedge reset);
		forever begin
			@(negedge uart_clock);
			if (uart_tx === 1'b0) begin
				repeat (`BYTE_WIDTH) begin
					@(negedge uart_clock);
					data = {uart_tx, data[`BYTE_WIDTH-1:1]};
				end
				@(negedge uart_clock);
				if (uart_tx !== 1'b1)
					fail_run("Stop bit on uart_tx was not high");
				received.push_back(data);
			end
		end
	end

	initial begin : compare_process
		logic [`BYTE_WIDTH-1:0] got;
		logic [`BYTE_WIDTH-1:0] want;
		forever begin
			@(posedge uart_clock);
			if (received.size() != 0) begin
				got = received.pop_front();
				if (expected.size() == 0)
					fail_run($sformatf("Unexpected character 0x%h received on uart_tx", got));
				else begin
					want = expected.pop_front();
					check_value("uart_tx character", 32'(got), 32'(want));
				end
			end
		end
	end

	initial begin : watchdog
		#((command_count * 40 * 10 + 100) * clock_period);
		fail_run("Watchdog timeout, the commands did not complete in time");
	end

	initial begin : stimulus
		logic [`ADDRESS_WIDTH-1:0] address;
		logic [`REG_WIDTH-1:0] value;
		int digit;
		reset = 1'b1;
		uart_rx = 1'b1;
		program_counter = '0;
		rng_state = 32'hd72e;
		repeat (2) @(posedge uart_clock);
		#2 reset = 1'b0;
		repeat (20) @(posedge uart_clock);
		check_value("uart_tx", 32'(uart_tx), 32'd1);
		check_pulses(); // Quiet before any command
		run_command("C");
		run_command("S");
		run_command("R");
		rng_state = xorshift(rng_state);
		digit = rng_state % 10;
		run_command($sformatf("+ %0d", digit));
		check_value("step_count", 32'(step_count), digit);
		rng_state = xorshift(rng_state);
		@(posedge uart_clock);
		#2 program_counter = rng_state[`PC_WIDTH-1:0];
		run_command("p");
		for (int iteration = 0; iteration < rounds; iteration++) begin
			rng_state = xorshift(rng_state);
			address = rng_state[`ADDRESS_WIDTH-1:0];
			value = rng_state[`REG_WIDTH+7:8];
			run_command($sformatf("W %06b %016b", address, value));
			check_value("reg_model", 32'(reg_model[address]), 32'(value));
			run_command($sformatf("G %06b", address));
			rng_state = xorshift(rng_state);
			address = rng_state[`ADDRESS_WIDTH-1:0];
			run_command($sformatf("E %06b %08b", address, rng_state[15:8]));
			check_value("data_model", 32'(data_model[address]), 32'(rng_state[15:8]));
			run_command($sformatf("D %06b", address));
		end
		repeat (40) @(posedge uart_clock); // Line must stay quiet
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src/debug_uart.sv
`default_nettype none
`timescale 1ns/1ns

`include "debug_uart_cfg.svh"

module debug_uart (
	input wire uart_clock,
	input wire reset,
	input wire uart_rx,
	output logic uart_tx,
	output logic cpu_continue,
	output logic cpu_stop,
	output logic cpu_reset,
	output logic cpu_step,
	output logic [`STEP_WIDTH-1:0] step_count,
	output logic [`ADDRESS_WIDTH-1:0] reg_read_address,
	input wire [`REG_WIDTH-1:0] reg_read_data,
	output logic [`ADDRESS_WIDTH-1:0] reg_write_address,
	output logic [`REG_WIDTH-1:0] reg_write_data,
	output logic reg_write_enable,
	output logic [`ADDRESS_WIDTH-1:0] data_read_address,
	input wire [`DATA_WIDTH-1:0] data_read_data,
	output logic [`ADDRESS_WIDTH-1:0] data_write_address,
	output logic [`DATA_WIDTH-1:0] data_write_data,
	output logic data_write_enable,
	input wire [`PC_WIDTH-1:0] program_counter
);

	logic [`BYTE_WIDTH-1:0] rx_byte;
	logic rx_valid;
	logic push;
	logic [`BYTE_WIDTH-1:0] push_byte;
	logic [`BYTE_WIDTH-1:0] head_byte;
	logic empty;
	logic pop;

	uart_receiver i_receiver (.uart_clock, .reset, .uart_rx, .rx_byte, .rx_valid);

	command_decoder i_decoder (
		.uart_clock, .reset, .rx_byte, .rx_valid,
		.reg_read_data, .data_read_data, .program_counter,
		.push, .push_byte,
		.cpu_continue, .cpu_stop, .cpu_reset, .cpu_step, .step_count,
		.reg_read_address, .reg_write_address, .reg_write_data, .reg_write_enable,
		.data_read_address, .data_write_address, .data_write_data, .data_write_enable
	);

	// Replies and echoes queue here while the line is busy
	reply_buffer i_buffer (.uart_clock, .reset, .push, .push_byte, .pop, .head_byte, .empty);

	uart_transmitter i_transmitter (.uart_clock, .reset, .head_byte, .empty, .pop, .uart_tx);

endmodule

`default_nettype wire

// File: src/uart_transmitter.sv
`default_nettype none
`timescale 1ns/1ns

`include "debug_uart_cfg.svh"

module uart_transmitter import uart_pkg::*; (
	input wire uart_clock,
	input wire reset,
	input wire uart_byte_t head_byte,
	input wire empty,
	output logic pop,
	output logic uart_tx
);

	typedef logic [$clog2(`BYTE_WIDTH)-1:0] bit_count_t;

	tx_state_t state;
	uart_byte_t shift;
	bit_count_t bit_count;

	// Next character may follow straight after the stop bit
	assign pop = (state == TX_IDLE || state == TX_STOP) && !empty;

	always_ff @(posedge uart_clock or posedge reset) begin
		if (reset) begin
			state <= TX_IDLE;
			bit_count <= '0;
			uart_tx <= 1'b1;
		end else begin
			case (state)
				TX_IDLE, TX_STOP: begin
					if (!empty) begin
						state <= TX_START;
						uart_tx <= 1'b0;
					end else
						state <= TX_IDLE;
				end
				TX_START: begin
					state <= TX_DATA;
					uart_tx <= shift[0];
					bit_count <= '0;
				end
				TX_DATA: begin
					if (bit_count == bit_count_t'(`BYTE_WIDTH - 1)) begin
						state <= TX_STOP;
						uart_tx <= 1'b1;
					end else begin
						uart_tx <= shift[0];
						bit_count <= bit_count + 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge uart_clock) begin
		if (pop)
			shift <= head_byte;
		else if (state == TX_START || state == TX_DATA)
			shift <= shift >> 1; // LSB first
	end

endmodule

`default_nettype wire

// File: src/reply_buffer.sv
`default_nettype none
`timescale 1ns/1ns

`include "debug_uart_cfg.svh"

module reply_buffer import uart_pkg::*; (
	input wire uart_clock,
	input wire reset,
	input wire push,
	input wire uart_byte_t push_byte,
	input wire pop,
	output uart_byte_t head_byte,
	output logic empty
);

	typedef logic [$clog2(`REPLY_DEPTH)-1:0] pointer_t;
	typedef logic [$clog2(`REPLY_DEPTH):0] count_t;

	uart_byte_t store [`REPLY_DEPTH];
	pointer_t read_pointer;
	pointer_t write_pointer;
	count_t count;
	logic full;
	logic do_push;
	logic do_pop;

	function automatic pointer_t advance(input pointer_t pointer);
		if (pointer == pointer_t'(`REPLY_DEPTH - 1))
			return '0;
		return pointer + 1'b1;
	endfunction

	assign full = count == count_t'(`REPLY_DEPTH);
	assign empty = count == '0;
	assign do_push = push && !full; // Lost when full
	assign do_pop = pop && !empty;
	assign head_byte = store[read_pointer];

	always_ff @(posedge uart_clock) begin
		if (do_push)
			store[write_pointer] <= push_byte;
	end

	always_ff @(posedge uart_clock or posedge reset) begin
		if (reset) begin
			read_pointer <= '0;
			write_pointer <= '0;
			count <= '0;
		end else begin
			if (do_push)
				write_pointer <= advance(write_pointer);
			if (do_pop)
				read_pointer <= advance(read_pointer);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/command_decoder.sv
`default_nettype none
`timescale 1ns/1ns

`include "debug_uart_cfg.svh"

module command_decoder import uart_pkg::*, monitor_pkg::*; (
	input wire uart_clock,
	input wire reset,
	input wire uart_byte_t rx_byte,
	input wire rx_valid,
	input wire [`REG_WIDTH-1:0] reg_read_data,
	input wire [`DATA_WIDTH-1:0] data_read_data,
	input wire [`PC_WIDTH-1:0] program_counter,
	output logic push,
	output uart_byte_t push_byte,
	output logic cpu_continue,
	output logic cpu_stop,
	output logic cpu_reset,
	output logic cpu_step,
	output logic [`STEP_WIDTH-1:0] step_count,
	output logic [`ADDRESS_WIDTH-1:0] reg_read_address,
	output logic [`ADDRESS_WIDTH-1:0] reg_write_address,
	output logic [`REG_WIDTH-1:0] reg_write_data,
	output logic reg_write_enable,
	output logic [`ADDRESS_WIDTH-1:0] data_read_address,
	output logic [`ADDRESS_WIDTH-1:0] data_write_address,
	output logic [`DATA_WIDTH-1:0] data_write_data,
	output logic data_write_enable
);

	typedef logic [$clog2(`LINE_LENGTH)-1:0] line_index_t;
	typedef logic [$clog2(`REG_WIDTH)-1:0] bit_index_t;
	typedef logic [`REG_WIDTH-1:0] word_t;

	uart_byte_t line [`LINE_LENGTH];
	line_index_t line_index;
	command_t command;
	reply_state_t reply_state;
	bit_index_t bit_index;
	bit_index_t value_msb;
	logic echo_valid;
	uart_byte_t echo_byte;
	uart_byte_t step_char;
	logic [`ADDRESS_WIDTH-1:0] line_address;
	word_t line_data;
	word_t field_word;

	// ASCII 0 and 1 differ only in bit 0
	always_comb begin
		for (int i = 0; i < `ADDRESS_WIDTH; i++)
			line_address[`ADDRESS_WIDTH - 1 - i] = line[`ADDRESS_FIRST + i][0];
		for (int i = 0; i < `REG_WIDTH; i++)
			line_data[`REG_WIDTH - 1 - i] = line[`DATA_FIRST + i][0];
	end

	assign step_char = line[`ADDRESS_FIRST] - `ASCII_ZERO;

	// Word whose bits go out as digits MSB first
	always_comb begin
		case (command)
			CMD_READ_REG: field_word = reg_read_data;
			CMD_WRITE_REG: field_word = reg_write_data;
			CMD_READ_DATA: field_word = word_t'(data_read_data);
			CMD_WRITE_DATA: field_word = word_t'(data_write_data);
			CMD_PC: field_word = word_t'(program_counter);
			default: field_word = '0;
		endcase
		if (reply_state == REPLY_ADDRESS)
			field_word = command == CMD_WRITE_REG ? word_t'(reg_write_address)
				: word_t'(data_write_address);
	end

	always_comb begin
		case (command)
			CMD_READ_DATA, CMD_WRITE_DATA: value_msb = bit_index_t'(`DATA_WIDTH - 1);
			CMD_PC: value_msb = bit_index_t'(`PC_WIDTH - 1);
			default: value_msb = bit_index_t'(`REG_WIDTH - 1);
		endcase
	end

	assign push = echo_valid || reply_state != REPLY_IDLE;

	always_comb begin
		case (reply_state)
			REPLY_ADDRESS, REPLY_VALUE: push_byte = `ASCII_ZERO + uart_byte_t'(field_word[bit_index]);
			REPLY_LEAD_SPACE, REPLY_MID_SPACE: push_byte = `ASCII_SPACE;
			default: push_byte = echo_byte;
		endcase
	end

	always_ff @(posedge uart_clock) begin
		if (rx_valid && rx_byte != `ASCII_CR)
			line[line_index] <= rx_byte;
		echo_byte <= rx_byte;
	end

	always_ff @(posedge uart_clock or posedge reset) begin
		if (reset) begin
			line_index <= '0;
			command <= CMD_CONTINUE;
			reply_state <= REPLY_IDLE;
			bit_index <= '0;
			echo_valid <= 1'b0;
			cpu_continue <= 1'b0;
			cpu_stop <= 1'b0;
			cpu_reset <= 1'b0;
			cpu_step <= 1'b0;
			step_count <= '0;
			reg_read_address <= '0;
			reg_write_address <= '0;
			reg_write_data <= '0;
			reg_write_enable <= 1'b0;
			data_read_address <= '0;
			data_write_address <= '0;
			data_write_data <= '0;
			data_write_enable <= 1'b0;
		end else begin
			cpu_continue <= 1'b0;
			cpu_stop <= 1'b0;
			cpu_reset <= 1'b0;
			cpu_step <= 1'b0;
			reg_write_enable <= 1'b0;
			data_write_enable <= 1'b0;
			echo_valid <= rx_valid && rx_byte != `ASCII_CR && reply_state == REPLY_IDLE;

			case (reply_state)
				REPLY_LEAD_SPACE: begin
					bit_index <= value_msb;
					if (command == CMD_WRITE_REG || command == CMD_WRITE_DATA) begin
						reply_state <= REPLY_ADDRESS;
						bit_index <= bit_index_t'(`ADDRESS_WIDTH - 1);
					end else if (command == CMD_READ_REG || command == CMD_READ_DATA
						|| command == CMD_PC)
						reply_state <= REPLY_VALUE;
					else
						reply_state <= REPLY_IDLE; // Space only
				end
				REPLY_ADDRESS: begin
					if (bit_index == '0)
						reply_state <= REPLY_MID_SPACE;
					else
						bit_index <= bit_index - 1'b1;
				end
				REPLY_MID_SPACE: begin
					reply_state <= REPLY_VALUE;
					bit_index <= value_msb;
				end
				REPLY_VALUE: begin
					if (bit_index == '0)
						reply_state <= REPLY_IDLE;
					else
						bit_index <= bit_index - 1'b1;
				end
				default: ;
			endcase

			if (rx_valid && rx_byte == `ASCII_CR) begin
				line_index <= '0;
				command <= command_t'(line[0]);
				reply_state <= REPLY_LEAD_SPACE;
				case (command_t'(line[0]))
					CMD_CONTINUE: cpu_continue <= 1'b1;
					CMD_STOP: cpu_stop <= 1'b1;
					CMD_RESET: cpu_reset <= 1'b1;
					CMD_STEP: begin
						cpu_step <= 1'b1;
						step_count <= step_char[`STEP_WIDTH-1:0];
					end
					CMD_READ_REG: reg_read_address <= line_address;
					CMD_WRITE_REG: begin
						reg_write_address <= line_address;
						reg_write_data <= line_data;
						reg_write_enable <= 1'b1;
					end
					CMD_READ_DATA: data_read_address <= line_address;
					CMD_WRITE_DATA: begin
						data_write_address <= line_address;
						data_write_data <= line_data[`REG_WIDTH-1 -: `DATA_WIDTH];
						data_write_enable <= 1'b1;
					end
					CMD_PC: ;
					default: reply_state <= REPLY_IDLE; // Unknown command sends nothing
				endcase
			end else if (rx_valid && line_index != line_index_t'(`LINE_LENGTH - 1))
				line_index <= line_index + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: src/uart_receiver.sv
`default_nettype none
`timescale 1ns/1ns

`include "debug_uart_cfg.svh"

module uart_receiver import uart_pkg::*; (
	input wire uart_clock,
	input wire reset,
	input wire uart_rx,
	output uart_byte_t rx_byte,
	output logic rx_valid
);

	typedef logic [$clog2(`BYTE_WIDTH)-1:0] bit_count_t;

	rx_state_t state;
	bit_count_t bit_count;

	assign rx_valid = state == RX_STOP; // High for the stop bit cycle

	always_ff @(posedge uart_clock or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			bit_count <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					if (!uart_rx) begin // Start bit
						state <= RX_DATA;
						bit_count <= '0;
					end
				end
				RX_DATA: begin
					if (bit_count == bit_count_t'(`BYTE_WIDTH - 1))
						state <= RX_STOP;
					bit_count <= bit_count + 1'b1;
				end
				RX_STOP: state <= RX_IDLE; // Line level not checked
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first and shifts towards bit 0
	always_ff @(posedge uart_clock) begin
		if (state == RX_DATA)
			rx_byte <= {uart_rx, rx_byte[`BYTE_WIDTH-1:1]};
	end

endmodule

`default_nettype wire

// File: src/monitor_pkg.sv
`default_nettype none

`include "debug_uart_cfg.svh"

package monitor_pkg;

	// Opcodes sit at their ASCII codes so line[0] casts straight in
	typedef enum logic [`BYTE_WIDTH-1:0] {
		CMD_STEP = 8'd43,
		CMD_CONTINUE = 8'd67,
		CMD_READ_DATA = 8'd68,
		CMD_WRITE_DATA = 8'd69,
		CMD_READ_REG = 8'd71,
		CMD_RESET = 8'd82,
		CMD_STOP = 8'd83,
		CMD_WRITE_REG = 8'd87,
		CMD_PC = 8'd112
	} command_t;

	typedef enum logic [2:0] {REPLY_IDLE, REPLY_LEAD_SPACE, REPLY_ADDRESS, REPLY_MID_SPACE,
		REPLY_VALUE} reply_state_t;

endpackage

`default_nettype wire

// File: src/uart_pkg.sv
`default_nettype none

`include "debug_uart_cfg.svh"

package uart_pkg;

	typedef logic [`BYTE_WIDTH-1:0] uart_byte_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage

`default_nettype wire

// File: src/debug_uart_cfg.svh
`ifndef DEBUG_UART_CFG_SVH
`define DEBUG_UART_CFG_SVH

// Character and storage sizes
`define BYTE_WIDTH 8
`define LINE_LENGTH 32
`define REPLY_DEPTH 32

// Processor side widths
`define ADDRESS_WIDTH 6
`define REG_WIDTH 16
`define DATA_WIDTH 8
`define PC_WIDTH 7
`define STEP_WIDTH 5

// Character codes
`define ASCII_ZERO 8'd48
`define ASCII_SPACE 8'd32
`define ASCII_CR 8'd13

// Field positions in the command line
`define ADDRESS_FIRST 2 // Address MSB
`define DATA_FIRST 9 // Write data MSB

`endif
